/* build.f */
tiny_pkg.sv
tiny_fetch.sv
tiny_lsu.sv
tiny_exec.sv
tiny_core.sv
tiny_core_assertions.sv
tiny_core_tb_top.sv

/* run.sh */
#!/bin/sh
# Build the tiny_core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tiny_core_tb_top \
  -f build.f -o sim_tiny_core
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit $status
fi

./obj_dir/sim_tiny_core
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed"
  exit $status
fi
exit 0

/* tiny_core.sv */
/* Top level of the tiny_core processor.
   Connects fetch, execute and load/store units to the memory and trace ports. */
`timescale 1ns/1ps

module tiny_core (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      fetch_enable_i,
  output logic                      instr_req_o,
  output tiny_pkg::mem_req_t        instr_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  logic [tiny_pkg::XLEN-1:0] instr_rdata_i,
  output logic                      data_req_o,
  output tiny_pkg::mem_req_t        data_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  input  logic [tiny_pkg::XLEN-1:0] data_rdata_i,
  output logic                      rvfi_valid_o,
  output tiny_pkg::retire_t         rvfi_o,
  output logic                      core_sleep_o
);
  import tiny_pkg::*;

  logic [XLEN-1:0] instr_addr;
  logic            fetch_valid;
  fetch_t          fetch;
  logic            fetch_credit;
  logic            lsu_valid;
  lsu_req_t        lsu_req;
  logic            lsu_done;
  logic [XLEN-1:0] lsu_rdata;
  logic            halt;

  // Instruction port never writes
  assign instr_o.addr  = instr_addr;
  assign instr_o.we    = 1'b0;
  assign instr_o.wdata = '0;

  assign core_sleep_o = halt;

  tiny_fetch u_fetch (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_enable_i (fetch_enable_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .fetch_credit_i (fetch_credit),
    .fetch_valid_o  (fetch_valid),
    .fetch_o        (fetch),
    .halt_i         (halt)
  );

  tiny_lsu u_lsu (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .lsu_valid_i   (lsu_valid),
    .lsu_req_i     (lsu_req),
    .data_req_o    (data_req_o),
    .data_o        (data_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .lsu_done_o    (lsu_done),
    .lsu_rdata_o   (lsu_rdata)
  );

  tiny_exec u_exec (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_valid_i  (fetch_valid),
    .fetch_i        (fetch),
    .fetch_credit_o (fetch_credit),
    .lsu_valid_o    (lsu_valid),
    .lsu_req_o      (lsu_req),
    .lsu_done_i     (lsu_done),
    .lsu_rdata_i    (lsu_rdata),
    .rvfi_valid_o   (rvfi_valid_o),
    .rvfi_o         (rvfi_o),
    .halt_o         (halt)
  );

endmodule

/* tiny_core_assertions.sv */
/* Protocol checks for tiny_core, bound into the core from the testbench.
   Shadow counters follow credits, data responses and retirement order. */
`timescale 1ns/1ps

module tiny_core_assertions (
  input logic                      clk_i,
  input logic                      reset_i,
  input logic                      instr_req_i,
  input tiny_pkg::mem_req_t        instr_i,
  input logic                      instr_gnt_i,
  input logic                      data_req_i,
  input tiny_pkg::mem_req_t        data_i,
  input logic                      data_gnt_i,
  input logic                      data_rvalid_i,
  input logic                      fetch_credit_i,
  input logic                      rvfi_valid_i,
  input tiny_pkg::retire_t         rvfi_i
);
  import tiny_pkg::*;

  int          credits;
  int          data_out;
  logic [31:0] next_order;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits    <= IQ_DEPTH;
      data_out   <= 0;
      next_order <= '0;
    end else begin
      credits  <= credits - ((instr_req_i && instr_gnt_i) ? 1 : 0) + (fetch_credit_i ? 1 : 0);
      data_out <= data_out + ((data_req_i && data_gnt_i) ? 1 : 0) - (data_rvalid_i ? 1 : 0);
      if (rvfi_valid_i) begin
        next_order <= next_order + 32'd1;
      end
    end
  end

  instr_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_i))
    else $error("Instruction request changed before its grant");

  data_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    data_req_i && !data_gnt_i |=> data_req_i && $stable(data_i))
    else $error("Data request changed before its grant");

  credit_range: assert property (@(posedge clk_i) disable iff (reset_i)
    credits >= 0 && credits <= IQ_DEPTH)
    else $error("Fetch credit count out of range");

  order_step: assert property (@(posedge clk_i) disable iff (reset_i)
    rvfi_valid_i |-> rvfi_i.order == next_order)
    else $error("Retirement order did not rise by one");

  rvalid_outstanding: assert property (@(posedge clk_i) disable iff (reset_i)
    data_rvalid_i |-> data_out > 0)
    else $error("Data response without an outstanding request");

endmodule

/* tiny_core_tb_top.sv */
/* Self-checking testbench for tiny_core. Models both memories, runs small
   programs with and without random handshake delays, and checks each
   retirement record against an instruction set model. */
`timescale 1ns/1ps

module tiny_core_tb_top;
  import tiny_pkg::*;

  logic            clk;
  logic            reset;
  logic            fetch_enable;
  logic            instr_req;
  mem_req_t        instr_bus;
  logic            instr_gnt;
  logic            instr_rvalid;
  logic [XLEN-1:0] instr_rdata;
  logic            data_req;
  mem_req_t        data_bus;
  logic            data_gnt;
  logic            data_rvalid;
  logic [XLEN-1:0] data_rdata;
  logic            rvfi_valid;
  retire_t         rvfi;
  logic            core_sleep;

  logic [31:0] imem [logic [31:0]];
  logic [31:0] dmem [logic [31:0]];
  logic [31:0] ref_dmem [logic [31:0]];
  logic [31:0] ref_regs [8];
  logic [31:0] ref_pc;
  logic [31:0] ref_order;
  logic [31:0] ipend [$];
  logic [31:0] dpend [$];
  logic [31:0] next_fetch;
  int          ig_wait;
  int          ir_wait;
  int          dg_wait;
  int          dr_wait;
  bit          rand_delays;
  int          prog_len;
  int          retired;
  int          cycles;
  int          budget = 60;

  tiny_core dut_i (
    .clk_i          (clk),
    .reset_i        (reset),
    .fetch_enable_i (fetch_enable),
    .instr_req_o    (instr_req),
    .instr_o        (instr_bus),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_rdata_i  (instr_rdata),
    .data_req_o     (data_req),
    .data_o         (data_bus),
    .data_gnt_i     (data_gnt),
    .data_rvalid_i  (data_rvalid),
    .data_rdata_i   (data_rdata),
    .rvfi_valid_o   (rvfi_valid),
    .rvfi_o         (rvfi),
    .core_sleep_o   (core_sleep)
  );

  bind tiny_core tiny_core_assertions u_assertions (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_req_i    (instr_req_o),
    .instr_i        (instr_o),
    .instr_gnt_i    (instr_gnt_i),
    .data_req_i     (data_req_o),
    .data_i         (data_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .fetch_credit_i (fetch_credit),
    .rvfi_valid_i   (rvfi_valid_o),
    .rvfi_i         (rvfi_o)
  );

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped on a failed check");
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected) else
      fail_now($sformatf("Fail rvfi.%s got %h expected %h", name, got, expected));
  endtask

  function automatic logic [31:0] enc(input logic [3:0] op, input logic [2:0] rd,
                                      input logic [2:0] rs1, input logic [2:0] rs2,
                                      input logic [15:0] imm);
    return {op, rd, rs1, rs2, 3'b000, imm};
  endfunction

  // Unwritten words read back as a pattern of their address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ 32'h5A5A_C3C3;
  endfunction

  function automatic int pick_delay();
    return rand_delays ? int'($urandom % 4) : 0;
  endfunction

  // Instruction set model that runs one instruction per call
  function automatic retire_t ref_step();
    retire_t     r;
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    word = imem.exists(ref_pc) ? imem[ref_pc] : fill_word(ref_pc);
    a    = ref_regs[word[24:22]];
    b    = ref_regs[word[21:19]];
    imm  = {{16{word[15]}}, word[15:0]};
    r        = '0;
    r.order  = ref_order;
    r.pc     = ref_pc;
    r.insn   = word;
    case (word[31:28])
      OP_ADD:  r.rd_wdata = a + b;
      OP_SUB:  r.rd_wdata = a - b;
      OP_AND:  r.rd_wdata = a & b;
      OP_XOR:  r.rd_wdata = a ^ b;
      OP_ADDI: r.rd_wdata = a + imm;
      OP_LOAD: begin
        r.mem_valid = 1'b1;
        r.mem_addr  = a + imm;
        r.mem_rdata = ref_dmem.exists(r.mem_addr) ? ref_dmem[r.mem_addr]
                                                  : fill_word(r.mem_addr);
        r.rd_wdata  = r.mem_rdata;
      end
      OP_STORE: begin
        r.mem_valid = 1'b1;
        r.mem_we    = 1'b1;
        r.mem_addr  = a + imm;
        r.mem_wdata = b;
        ref_dmem[r.mem_addr] = b;
      end
      OP_HALT: ;
      default: r.trap = 1'b1;
    endcase
    if (word[31:28] <= 4'd5) begin
      r.rd_addr = word[27:25];
    end
    // r0 is never written
    if (r.rd_addr != '0) begin
      ref_regs[r.rd_addr] = r.rd_wdata;
    end
    ref_pc    = ref_pc + 32'd4;
    ref_order = ref_order + 32'd1;
    return r;
  endfunction

  task automatic load_program(input int id);
    logic [31:0] p [$];
    case (id)
      0: begin
        // ALU ops, negative immediates and wrap-around
        p.push_back(enc(OP_ADDI, 1, 0, 0, 16'd5));
        p.push_back(enc(OP_ADDI, 2, 0, 0, 16'hFFFD));
        p.push_back(enc(OP_ADD, 3, 1, 2, 16'd0));
        p.push_back(enc(OP_SUB, 4, 2, 1, 16'd0));
        p.push_back(enc(OP_AND, 5, 1, 2, 16'd0));
        p.push_back(enc(OP_XOR, 6, 1, 2, 16'd0));
        p.push_back(enc(OP_ADDI, 7, 0, 0, 16'h8000));
        p.push_back(enc(OP_SUB, 7, 7, 1, 16'd0));
        p.push_back(enc(OP_ADDI, 1, 0, 0, 16'hFFFF));
        p.push_back(enc(OP_ADDI, 1, 1, 0, 16'd1));
      end
      1: begin
        // Stores followed by loads of the same and of untouched words
        p.push_back(enc(OP_ADDI, 1, 0, 0, 16'h0100));
        p.push_back(enc(OP_ADDI, 2, 0, 0, 16'hFFF9));
        p.push_back(enc(OP_STORE, 0, 1, 2, 16'd4));
        p.push_back(enc(OP_LOAD, 3, 1, 0, 16'd4));
        p.push_back(enc(OP_LOAD, 4, 1, 0, 16'hFFF8));
        p.push_back(enc(OP_ADD, 5, 3, 4, 16'd0));
        p.push_back(enc(OP_STORE, 0, 1, 5, 16'd0));
        p.push_back(enc(OP_LOAD, 6, 1, 0, 16'd0));
        p.push_back(enc(OP_XOR, 7, 6, 5, 16'd0));
      end
      default: begin
        // r0 writes and illegal opcodes
        p.push_back(enc(OP_ADDI, 0, 0, 0, 16'd9));
        p.push_back(enc(OP_ADD, 1, 0, 0, 16'd0));
        p.push_back(enc(OP_ADDI, 1, 0, 0, 16'd3));
        p.push_back(enc(4'hC, 1, 1, 1, 16'h1234));
        p.push_back(enc(OP_ADD, 2, 1, 0, 16'd0));
        p.push_back(enc(4'h8, 2, 2, 2, 16'd0));
        p.push_back(enc(OP_SUB, 0, 2, 1, 16'd0));
        p.push_back(enc(OP_ADD, 3, 0, 2, 16'd0));
      end
    endcase
    p.push_back(enc(OP_HALT, 0, 0, 0, 16'd0));
    imem.delete();
    foreach (p[i]) begin
      imem[BOOT_ADDR + 32'(4 * i)] = p[i];
    end
    prog_len = p.size();
  endtask

  task automatic run_program(input int id, input bit rnd);
    @(posedge clk);
    #1;
    reset        = 1'b1;
    fetch_enable = 1'b0;
    rand_delays  = rnd;
    load_program(id);
    dmem.delete();
    ref_dmem.delete();
    foreach (ref_regs[i]) begin
      ref_regs[i] = '0;
    end
    ref_pc    = BOOT_ADDR;
    ref_order = '0;
    retired   = 0;
    budget    = cycles + 200 * prog_len + 40;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (6) begin
      @(posedge clk);
      #1;
      assert (!instr_req) else fail_now("Instruction request while fetch was disabled");
    end
    fetch_enable = 1'b1;
    while (!core_sleep) begin
      @(posedge clk);
      #1;
    end
    repeat (20) begin
      @(posedge clk);
      #1;
      assert (core_sleep) else fail_now("core_sleep_o dropped after HALT retired");
    end
    assert (retired == prog_len) else
      fail_now($sformatf("Retired %0d instructions for a program of %0d", retired, prog_len));
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Both memory ports are driven just after each rising edge
  initial begin
    forever begin
      @(posedge clk);
      #1;
      instr_rvalid = 1'b0;
      instr_gnt    = 1'b0;
      data_rvalid  = 1'b0;
      data_gnt     = 1'b0;
      if (reset) begin
        ipend.delete();
        dpend.delete();
        next_fetch = BOOT_ADDR;
        ig_wait    = 0;
        ir_wait    = 0;
        dg_wait    = 0;
        dr_wait    = 0;
      end else begin
        if (ipend.size() != 0) begin
          if (ir_wait == 0) begin
            instr_rvalid = 1'b1;
            instr_rdata  = ipend.pop_front();
            ir_wait      = pick_delay();
          end else begin
            ir_wait--;
          end
        end
        if (instr_req) begin
          // Instruction fetches never write
          assert (instr_bus.we === 1'b0) else
            fail_now($sformatf("Fail instr_o.we got %h expected 0", instr_bus.we));
          assert (instr_bus.wdata === '0) else
            fail_now($sformatf("Fail instr_o.wdata got %h expected 0", instr_bus.wdata));
          if (ig_wait == 0) begin
            assert (instr_bus.addr === next_fetch) else
              fail_now($sformatf("Fail instr_o.addr got %h expected %h",
                                 instr_bus.addr, next_fetch));
            instr_gnt = 1'b1;
            ipend.push_back(imem.exists(next_fetch) ? imem[next_fetch] : fill_word(next_fetch));
            next_fetch = next_fetch + 32'd4;
            ig_wait    = pick_delay();
          end else begin
            ig_wait--;
          end
        end
        if (dpend.size() != 0) begin
          if (dr_wait == 0) begin
            data_rvalid = 1'b1;
            data_rdata  = dpend.pop_front();
            dr_wait     = pick_delay();
          end else begin
            dr_wait--;
          end
        end
        if (data_req) begin
          if (dg_wait == 0) begin
            data_gnt = 1'b1;
            if (data_bus.we) begin
              dmem[data_bus.addr] = data_bus.wdata;
              dpend.push_back('0);
            end else begin
              dpend.push_back(dmem.exists(data_bus.addr) ? dmem[data_bus.addr]
                                                         : fill_word(data_bus.addr));
            end
            dg_wait = pick_delay();
          end else begin
            dg_wait--;
          end
        end
      end
    end
  end

  // Trace comparator
  initial begin
    retire_t expected;
    forever begin
      @(posedge clk);
      #1;
      if (rvfi_valid) begin
        assert (retired < prog_len) else fail_now("Instruction retired after HALT");
        expected = ref_step();
        check_field("order", rvfi.order, expected.order);
        check_field("pc", rvfi.pc, expected.pc);
        check_field("insn", rvfi.insn, expected.insn);
        check_field("trap", 32'(rvfi.trap), 32'(expected.trap));
        check_field("rd_addr", 32'(rvfi.rd_addr), 32'(expected.rd_addr));
        check_field("rd_wdata", rvfi.rd_wdata, expected.rd_wdata);
        check_field("mem_valid", 32'(rvfi.mem_valid), 32'(expected.mem_valid));
        check_field("mem_we", 32'(rvfi.mem_we), 32'(expected.mem_we));
        check_field("mem_addr", rvfi.mem_addr, expected.mem_addr);
        check_field("mem_wdata", rvfi.mem_wdata, expected.mem_wdata);
        check_field("mem_rdata", rvfi.mem_rdata, expected.mem_rdata);
        retired++;
      end
    end
  end

  // Watchdog budget is renewed for every program
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      assert (cycles < budget) else fail_now("Timeout, the core did not halt in time");
    end
  end

  initial begin
    void'($urandom(6));
    reset        = 1'b1;
    fetch_enable = 1'b0;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    data_gnt     = 1'b0;
    data_rvalid  = 1'b0;
    data_rdata   = '0;
    rand_delays  = 1'b0;
    prog_len     = 0;
    retired      = 0;
    for (int id = 0; id < 3; id++) begin
      run_program(id, 1'b0);
      run_program(id, 1'b1);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

/* tiny_exec.sv */
/* Execute unit of tiny_core.
   Queues fetched words, decodes the head, runs the ALU or hands memory
   ops to the load/store unit, updates the registers and emits the trace. */
`timescale 1ns/1ps

module tiny_exec (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      fetch_valid_i,
  input  tiny_pkg::fetch_t          fetch_i,
  output logic                      fetch_credit_o,
  output logic                      lsu_valid_o,
  output tiny_pkg::lsu_req_t        lsu_req_o,
  input  logic                      lsu_done_i,
  input  logic [tiny_pkg::XLEN-1:0] lsu_rdata_i,
  output logic                      rvfi_valid_o,
  output tiny_pkg::retire_t         rvfi_o,
  output logic                      halt_o
);
  import tiny_pkg::*;

  fetch_t              iq_q [IQ_DEPTH];
  logic [IQ_PTR_W-1:0] wr_ptr_q;
  logic [IQ_PTR_W-1:0] rd_ptr_q;
  logic [CREDIT_W-1:0] iq_cnt_q;
  logic [XLEN-1:0]     regs_q [8];
  logic                lsu_credit_q;
  logic                halt_q;
  logic [31:0]         order_q;
  logic                rvfi_valid_q;
  retire_t             rvfi_q;

  fetch_t          head;
  insn_t           head_insn;
  logic            head_valid;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] imm_ext;
  logic [XLEN-1:0] mem_addr;
  logic [XLEN-1:0] result;
  logic            is_mem;
  logic            is_store;
  logic            writes_rd;
  logic            trap;
  logic            pop;
  retire_t         rvfi_d;

  assign head       = iq_q[rd_ptr_q];
  assign head_insn  = insn_t'(head.insn);
  // Nothing leaves the queue once HALT has retired
  assign head_valid = (iq_cnt_q != '0) && !halt_q;

  // Register 0 is hardwired to zero
  assign rs1_val  = (head_insn.rs1 == '0) ? '0 : regs_q[head_insn.rs1];
  assign rs2_val  = (head_insn.rs2 == '0) ? '0 : regs_q[head_insn.rs2];
  assign imm_ext  = {{(XLEN-16){head_insn.imm[15]}}, head_insn.imm};
  assign mem_addr = rs1_val + imm_ext;

  always_comb begin
    result    = '0;
    is_mem    = 1'b0;
    is_store  = 1'b0;
    writes_rd = 1'b1;
    trap      = 1'b0;
    case (head_insn.opcode)
      OP_ADD:  result = rs1_val + rs2_val;
      OP_SUB:  result = rs1_val - rs2_val;
      OP_AND:  result = rs1_val & rs2_val;
      OP_XOR:  result = rs1_val ^ rs2_val;
      OP_ADDI: result = rs1_val + imm_ext;
      OP_LOAD: begin
        is_mem = 1'b1;
        result = lsu_rdata_i;
      end
      OP_STORE: begin
        is_mem    = 1'b1;
        is_store  = 1'b1;
        writes_rd = 1'b0;
      end
      OP_HALT: writes_rd = 1'b0;
      default: begin
        trap      = 1'b1;
        writes_rd = 1'b0;
      end
    endcase
  end

  // Memory ops pop on lsu_done, everything else pops at once
  assign pop            = head_valid && (!is_mem || lsu_done_i);
  assign fetch_credit_o = pop;

  // Single credit toward the load/store unit
  assign lsu_valid_o     = head_valid && is_mem && lsu_credit_q;
  assign lsu_req_o.addr  = mem_addr;
  assign lsu_req_o.we    = is_store;
  assign lsu_req_o.wdata = is_store ? rs2_val : '0;

  always_comb begin
    rvfi_d       = '0;
    rvfi_d.order = order_q;
    rvfi_d.pc    = head.pc;
    rvfi_d.insn  = head.insn;
    rvfi_d.trap  = trap;
    if (writes_rd) begin
      rvfi_d.rd_addr  = head_insn.rd;
      rvfi_d.rd_wdata = result;
    end
    rvfi_d.mem_valid = is_mem;
    rvfi_d.mem_we    = is_store;
    if (is_mem) begin
      rvfi_d.mem_addr = mem_addr;
    end
    if (is_store) begin
      rvfi_d.mem_wdata = rs2_val;
    end else if (is_mem) begin
      rvfi_d.mem_rdata = lsu_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      iq_cnt_q     <= '0;
      lsu_credit_q <= 1'b1;
      halt_q       <= 1'b0;
      order_q      <= '0;
      rvfi_valid_q <= 1'b0;
      rvfi_q       <= '0;
      for (int i = 0; i < 8; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      if (fetch_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      iq_cnt_q <= iq_cnt_q + CREDIT_W'(fetch_valid_i) - CREDIT_W'(pop);
      if (lsu_valid_o) begin
        lsu_credit_q <= 1'b0;
      end else if (lsu_done_i) begin
        lsu_credit_q <= 1'b1;
      end
      rvfi_valid_q <= pop;
      if (pop) begin
        rvfi_q  <= rvfi_d;
        order_q <= order_q + 1'b1;
        // Write to r0 is dropped, trace still carries the value
        if (writes_rd && (head_insn.rd != '0)) begin
          regs_q[head_insn.rd] <= result;
        end
        if (head_insn.opcode == OP_HALT) begin
          halt_q <= 1'b1;
        end
      end
    end
  end

  // Queue storage, credits guarantee a free slot on every push
  always_ff @(posedge clk_i) begin
    if (fetch_valid_i) begin
      iq_q[wr_ptr_q] <= fetch_i;
    end
  end

  assign rvfi_valid_o = rvfi_valid_q;
  assign rvfi_o       = rvfi_q;
  assign halt_o       = halt_q;

endmodule

/* tiny_fetch.sv */
/* Sequential instruction fetch for tiny_core.
   Requests words while it holds credits and passes each returned word,
   tagged with its pc, to the execute unit one cycle after rvalid. */
`timescale 1ns/1ps

module tiny_fetch (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      fetch_enable_i,
  output logic                      instr_req_o,
  output logic [tiny_pkg::XLEN-1:0] instr_addr_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  logic [tiny_pkg::XLEN-1:0] instr_rdata_i,
  input  logic                      fetch_credit_i,
  output logic                      fetch_valid_o,
  output tiny_pkg::fetch_t          fetch_o,
  input  logic                      halt_i
);
  import tiny_pkg::*;

  logic                fetch_en_q;
  logic                req_hold_q;
  logic [CREDIT_W-1:0] credit_cnt_q;
  logic [XLEN-1:0]     req_addr_q;
  logic [XLEN-1:0]     ret_pc_q;
  logic                fetch_valid_q;
  fetch_t              fetch_q;
  logic                req_issue;
  logic                req_accept;

  // Fresh request needs enable, a free queue slot and no halt
  assign req_issue = fetch_en_q && !halt_i && (credit_cnt_q != '0);

  // A request that saw no grant stays up whatever happens to enable or halt
  assign instr_req_o  = req_hold_q || req_issue;
  assign instr_addr_o = req_addr_q;
  assign req_accept   = instr_req_o && instr_gnt_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fetch_en_q   <= 1'b0;
      req_hold_q   <= 1'b0;
      credit_cnt_q <= CREDIT_W'(IQ_DEPTH);
      req_addr_q   <= BOOT_ADDR;
    end else begin
      fetch_en_q <= fetch_enable_i;
      req_hold_q <= instr_req_o && !instr_gnt_i;
      if (req_accept) begin
        req_addr_q <= req_addr_q + XLEN'(4);
      end
      // One credit spent per grant, one returned per queue pop
      case ({req_accept, fetch_credit_i})
        2'b10:   credit_cnt_q <= credit_cnt_q - 1'b1;
        2'b01:   credit_cnt_q <= credit_cnt_q + 1'b1;
        default: credit_cnt_q <= credit_cnt_q;
      endcase
    end
  end

  // Return side, responses arrive in request order
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fetch_valid_q <= 1'b0;
      ret_pc_q      <= BOOT_ADDR;
    end else begin
      fetch_valid_q <= instr_rvalid_i;
      if (instr_rvalid_i) begin
        ret_pc_q <= ret_pc_q + XLEN'(4);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_rvalid_i) begin
      fetch_q.insn <= instr_rdata_i;
      fetch_q.pc   <= ret_pc_q;
    end
  end

  assign fetch_valid_o = fetch_valid_q;
  assign fetch_o       = fetch_q;

endmodule

/* tiny_lsu.sv */
/* Load/store unit of tiny_core.
   Runs a single access on the data memory port and reports completion
   with the load data through lsu_done_o. */
`timescale 1ns/1ps

module tiny_lsu (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      lsu_valid_i,
  input  tiny_pkg::lsu_req_t        lsu_req_i,
  output logic                      data_req_o,
  output tiny_pkg::mem_req_t        data_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  input  logic [tiny_pkg::XLEN-1:0] data_rdata_i,
  output logic                      lsu_done_o,
  output logic [tiny_pkg::XLEN-1:0] lsu_rdata_o
);
  import tiny_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT
  } lsu_state_e;

  lsu_state_e      state_q;
  lsu_state_e      state_d;
  mem_req_t        req_q;
  logic            done_q;
  logic [XLEN-1:0] rdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (lsu_valid_i) state_d = REQ;
      REQ:     if (data_gnt_i) state_d = WAIT;
      WAIT:    if (data_rvalid_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= (state_q == WAIT) && data_rvalid_i;
    end
  end

  // Request held stable from capture until grant
  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && lsu_valid_i) begin
      req_q.addr  <= lsu_req_i.addr;
      req_q.we    <= lsu_req_i.we;
      req_q.wdata <= lsu_req_i.wdata;
    end
    if ((state_q == WAIT) && data_rvalid_i) begin
      rdata_q <= data_rdata_i;
    end
  end

  assign data_req_o  = (state_q == REQ);
  assign data_o      = req_q;
  assign lsu_done_o  = done_q;
  assign lsu_rdata_o = rdata_q;

endmodule

/* tiny_pkg.sv */
/* Shared types and sizing constants for the tiny_core design.
   Imported by every block of the core and by its testbench. */
package tiny_pkg;

  localparam int XLEN = 32;
  localparam int IQ_DEPTH = 4;
  localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_0080;

  // Credit counter and queue fill level hold 0..IQ_DEPTH
  localparam int CREDIT_W = $clog2(IQ_DEPTH + 1);
  localparam int IQ_PTR_W = $clog2(IQ_DEPTH);

  // Values 8 to 15 are illegal
  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_XOR   = 4'd3,
    OP_ADDI  = 4'd4,
    OP_LOAD  = 4'd5,
    OP_STORE = 4'd6,
    OP_HALT  = 4'd7
  } opcode_e;

  typedef logic [2:0] reg_addr_t;

  typedef struct packed {
    opcode_e     opcode;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [2:0]  unused;
    logic [15:0] imm;
  } insn_t;

  typedef struct packed {
    logic [XLEN-1:0] insn;
    logic [XLEN-1:0] pc;
  } fetch_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic            we;
    logic [XLEN-1:0] wdata;
  } lsu_req_t;

  // Shared by the instruction and data memory ports
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic            we;
    logic [XLEN-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [31:0]     order;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] insn;
    logic            trap;
    reg_addr_t       rd_addr;
    logic [XLEN-1:0] rd_wdata;
    logic            mem_valid;
    logic            mem_we;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_wdata;
    logic [XLEN-1:0] mem_rdata;
  } retire_t;

endpackage
